//--- Makefile
# Verilator build and run for the cartridge bus testbench

VERILATOR ?= verilator
TOP       ?= tb_msx_cart_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/cart_data_driver.sv
`timescale 1ns/10ps

module cart_data_driver import msx_bus_pkg::*, sdc_pkg::*; (
    input  logic      clk108_w,
    input  logic      ram_enabled_w,
    msx_bus_if.client bus,
    input  byte_t     sdc_rd_data,
    input  logic      sdc_rd_hit,
    output byte_t     cd_out,
    output logic      datadir
);

    logic slot_rd;

    assign slot_rd = !bus.sltsl_n && !bus.rd_n;

    // read data latched once per dot cycle
    always_ff @(posedge clk108_w) begin
        if (bus.snap_stb)
            cd_out <= sdc_rd_hit ? sdc_rd_data : unmapped_byte;
    end

    //////////////////////////////////////////////////////////////////////
    // bus direction, low turns the transceiver toward the msx
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w)
            datadir <= 1'b1;
        else if (bus.snap_stb)
            datadir <= !slot_rd;
    end

    // outside the strobe cycle the driver and the snapshot agree
    a_dir_on_read: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        !bus.snap_stb && !datadir |-> !bus.rd_n);

endmodule

//--- rtl/megaram_config.sv
`timescale 1ns/10ps

module megaram_config import msx_bus_pkg::*, sdc_pkg::*; (
    input  logic          clk108_w,
    input  logic          ram_enabled_w,
    msx_bus_if.client     bus,
    output megaram_type_e megaram_type,
    output logic          scc_enable
);

    byte_t io_port;
    logic  cfg_wr;

    assign io_port = bus.addr[7:0];   // z80 i/o uses the low byte only
    assign cfg_wr  = bus.snap_stb && !bus.iorq_n && bus.m1_n && !bus.wr_n
                     && io_port == megaram_port;

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            megaram_type <= mt_konami;
            scc_enable   <= 1'b0;
        end else if (cfg_wr) begin
            scc_enable <= (bus.cdin == sel_konami_scc);
            case (bus.cdin)
                sel_konami_scc: megaram_type <= mt_konami_scc;
                sel_ascii16:    megaram_type <= mt_ascii16;
                sel_ascii8:     megaram_type <= mt_ascii8;
                default:        megaram_type <= mt_konami;   // anything else
            endcase
        end
    end

endmodule

//--- rtl/msx_bus_if.sv
`timescale 1ns/10ps

// one coherent cartridge bus snapshot per dot cycle
interface msx_bus_if import msx_bus_pkg::*; ();

    addr_t addr;
    byte_t cdin;      // data bus as seen on writes
    logic  merq_n;
    logic  iorq_n;
    logic  m1_n;
    logic  rd_n;
    logic  wr_n;
    logic  sltsl_n;
    logic  snap_stb;  // fields are new while this is high

    modport sampler (
        output addr, cdin, merq_n, iorq_n, m1_n, rd_n, wr_n, sltsl_n, snap_stb
    );

    modport client (
        input addr, cdin, merq_n, iorq_n, m1_n, rd_n, wr_n, sltsl_n, snap_stb
    );

endinterface

//--- rtl/msx_bus_pkg.sv
package msx_bus_pkg;

    localparam int addr_w = 16;
    localparam int data_w = 8;
    localparam int msel_w = 3;

    typedef logic [addr_w-1:0] addr_t;    // z80 address
    typedef logic [data_w-1:0] byte_t;
    typedef logic [msel_w-1:0] msel_t;    // active low mux select

    // one dot cycle is eight clk108 cycles, two per mux slot
    typedef enum logic [2:0] {
        ph_lo_sel   = 3'd0,
        ph_lo_cap   = 3'd1,
        ph_hi_sel   = 3'd2,
        ph_hi_cap   = 3'd3,
        ph_ctl_sel  = 3'd4,
        ph_ctl_cap  = 3'd5,
        ph_idle_sel = 3'd6,
        ph_idle_end = 3'd7
    } dot_phase_e;

    localparam msel_t msel_lo   = 3'b110;  // A0-A7
    localparam msel_t msel_hi   = 3'b101;  // A8-A15
    localparam msel_t msel_ctl  = 3'b011;  // control byte
    localparam msel_t msel_none = 3'b111;

    // control byte layout on mp
    localparam int ctl_merq_bit = 0;
    localparam int ctl_iorq_bit = 1;
    localparam int ctl_m1_bit   = 7;

endpackage

//--- rtl/msx_bus_sampler.sv
`timescale 1ns/10ps

module msx_bus_sampler import msx_bus_pkg::*; (
    input  logic      clk108_w,
    input  logic      ram_enabled_w,
    input  byte_t     mp,
    input  byte_t     cd_in,
    input  logic      rd_n,
    input  logic      wr_n,
    input  logic      sltsl_n,
    output msel_t     msel_n,
    msx_bus_if.sampler bus
);

    dot_phase_e phase;
    dot_phase_e phase_nxt;
    msel_t      msel_nxt;
    logic [2:0] pin_s1, pin_s2;   // {sltsl_n, wr_n, rd_n}
    byte_t      cd_s1, cd_s2;
    byte_t      addr_lo, addr_hi;

    assign phase_nxt = dot_phase_e'(phase + 3'd1);

    // select code is registered together with the phase it belongs to
    always_comb begin
        unique case (phase_nxt)
            ph_lo_sel, ph_lo_cap:     msel_nxt = msel_lo;
            ph_hi_sel, ph_hi_cap:     msel_nxt = msel_hi;
            ph_ctl_sel, ph_ctl_cap:   msel_nxt = msel_ctl;
            ph_idle_sel, ph_idle_end: msel_nxt = msel_none;
            default:                  msel_nxt = msel_none;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // dot sequencer
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            phase  <= ph_idle_end;   // first edge enters ph_lo_sel
            msel_n <= msel_none;
            pin_s1 <= 3'b111;
            pin_s2 <= 3'b111;
        end else begin
            phase  <= phase_nxt;
            msel_n <= msel_nxt;
            pin_s1 <= {sltsl_n, wr_n, rd_n};
            pin_s2 <= pin_s1;
        end
    end

    always_ff @(posedge clk108_w) begin
        cd_s1 <= cd_in;
        cd_s2 <= cd_s1;
        if (phase == ph_lo_cap) addr_lo <= mp;
        if (phase == ph_hi_cap) addr_hi <= mp;
        if (phase == ph_ctl_cap) begin
            bus.addr <= {addr_hi, addr_lo};
            bus.cdin <= cd_s2;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // snapshot publish, lands in ph_idle_sel
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            bus.merq_n   <= 1'b1;
            bus.iorq_n   <= 1'b1;
            bus.m1_n     <= 1'b1;
            bus.rd_n     <= 1'b1;
            bus.wr_n     <= 1'b1;
            bus.sltsl_n  <= 1'b1;
            bus.snap_stb <= 1'b0;
        end else begin
            bus.snap_stb <= (phase == ph_ctl_cap);
            if (phase == ph_ctl_cap) begin
                bus.merq_n  <= mp[ctl_merq_bit];
                bus.iorq_n  <= mp[ctl_iorq_bit];
                bus.m1_n    <= mp[ctl_m1_bit];
                bus.rd_n    <= pin_s2[0];
                bus.wr_n    <= pin_s2[1];
                bus.sltsl_n <= pin_s2[2];
            end
        end
    end

    // mux select must never enable two latches at once
    a_msel_single: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        $countones(~msel_n) <= 1);

endmodule

//--- rtl/msx_cart_top.sv
`timescale 1ns/10ps

module msx_cart_top import msx_bus_pkg::*, sdc_pkg::*; (
    input  logic          clk108_w,
    input  logic          ram_enabled_w,
    input  byte_t         mp,
    inout  wire byte_t    cd,
    input  logic          rd_n,
    input  logic          wr_n,
    input  logic          sltsl_n,
    output msel_t         msel_n,
    output logic          datadir,
    input  logic          sd_busy,
    input  logic          sd_done,
    input  logic          sd_crc_error,
    input  logic          sd_timeout_error,
    output logic          sd_rstart,
    output logic          sd_wstart,
    output logic          sd_init,
    output sector_t       sd_sector,
    output megaram_type_e megaram_type,
    output logic          scc_enable
);

    byte_t sdc_rd_data;
    logic  sdc_rd_hit;
    byte_t cd_out;

    msx_bus_if bus_if ();

    msx_bus_sampler i_msx_bus_sampler (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .cd_in         (cd),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .sltsl_n       (sltsl_n),
        .msel_n        (msel_n),
        .bus           (bus_if.sampler)
    );

    sdc_registers i_sdc_registers (
        .clk108_w         (clk108_w),
        .ram_enabled_w    (ram_enabled_w),
        .bus              (bus_if.client),
        .sd_busy          (sd_busy),
        .sd_done          (sd_done),
        .sd_crc_error     (sd_crc_error),
        .sd_timeout_error (sd_timeout_error),
        .sd_rstart        (sd_rstart),
        .sd_wstart        (sd_wstart),
        .sd_init          (sd_init),
        .sd_sector        (sd_sector),
        .sdc_rd_data      (sdc_rd_data),
        .sdc_rd_hit       (sdc_rd_hit)
    );

    megaram_config i_megaram_config (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .bus           (bus_if.client),
        .megaram_type  (megaram_type),
        .scc_enable    (scc_enable)
    );

    cart_data_driver i_cart_data_driver (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .bus           (bus_if.client),
        .sdc_rd_data   (sdc_rd_data),
        .sdc_rd_hit    (sdc_rd_hit),
        .cd_out        (cd_out),
        .datadir       (datadir)
    );

    assign cd = datadir ? 'z : cd_out;   // released unless a slot read

endmodule

//--- rtl/sdc_pkg.sv
package sdc_pkg;

    // sd controller register window, slot memory space
    localparam logic [15:0] sdc_enable_addr = 16'h7E00;  // bit 0 enables the window
    localparam logic [15:0] sdc_cmd_addr    = 16'h7E01;
    localparam logic [15:0] sdc_status_addr = 16'h7E02;
    localparam logic [15:0] sdc_saddr_addr  = 16'h7E03;  // 4 bytes, lsb first
    localparam logic [7:0]  sdc_window_page = 8'h7E;

    // command byte
    localparam int cmd_rstart_bit = 0;
    localparam int cmd_wstart_bit = 1;
    localparam int cmd_init_bit   = 7;

    // status byte
    localparam int status_busy_bit    = 7;
    localparam int status_timeout_bit = 1;
    localparam int status_crc_bit     = 0;

    typedef logic [31:0] sector_t;

    //////////////////////////////////////////////////////////////////////
    // megaram mapper config port

    localparam logic [7:0] megaram_port = 8'h8F;

    typedef enum logic [1:0] {
        mt_konami     = 2'd0,
        mt_konami_scc = 2'd1,
        mt_ascii16    = 2'd2,
        mt_ascii8     = 2'd3
    } megaram_type_e;

    localparam logic [7:0] sel_konami_scc = 8'h05;
    localparam logic [7:0] sel_ascii16    = 8'h16;
    localparam logic [7:0] sel_ascii8     = 8'h08;

    localparam logic [7:0] unmapped_byte = 8'hFF;  // floating bus value

endpackage

//--- rtl/sdc_registers.sv
`timescale 1ns/10ps

module sdc_registers import msx_bus_pkg::*, sdc_pkg::*; (
    input  logic      clk108_w,
    input  logic      ram_enabled_w,
    msx_bus_if.client bus,
    input  logic      sd_busy,
    input  logic      sd_done,
    input  logic      sd_crc_error,
    input  logic      sd_timeout_error,
    output logic      sd_rstart,
    output logic      sd_wstart,
    output logic      sd_init,
    output sector_t   sd_sector,
    output byte_t     sdc_rd_data,
    output logic      sdc_rd_hit
);

    logic sdc_en;
    logic slot_mem;
    logic wr_hit;

    // memory cycle into our slot
    assign slot_mem = !bus.sltsl_n && !bus.merq_n && bus.iorq_n;
    assign wr_hit   = bus.snap_stb && slot_mem && !bus.wr_n;

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            sdc_en    <= 1'b0;
            sd_rstart <= 1'b0;
            sd_wstart <= 1'b0;
            sd_init   <= 1'b0;
        end else begin
            if (wr_hit && bus.addr == sdc_enable_addr)
                sdc_en <= bus.cdin[0];   // reachable while disabled
            if (sd_done) begin
                // engine finished, done wins over a new request
                sd_rstart <= 1'b0;
                sd_wstart <= 1'b0;
            end else if (wr_hit && sdc_en && bus.addr == sdc_cmd_addr) begin
                sd_rstart <= sd_rstart | bus.cdin[cmd_rstart_bit];
                sd_wstart <= sd_wstart | bus.cdin[cmd_wstart_bit];
            end
            if (wr_hit && sdc_en && bus.addr == sdc_cmd_addr)
                sd_init <= sd_init | bus.cdin[cmd_init_bit];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sector address, lsb first
    always_ff @(posedge clk108_w) begin
        if (wr_hit && sdc_en) begin
            case (bus.addr)
                sdc_saddr_addr:         sd_sector[7:0]   <= bus.cdin;
                sdc_saddr_addr + 16'd1: sd_sector[15:8]  <= bus.cdin;
                sdc_saddr_addr + 16'd2: sd_sector[23:16] <= bus.cdin;
                sdc_saddr_addr + 16'd3: sd_sector[31:24] <= bus.cdin;
                default: ;
            endcase
        end
    end

    // read side follows the current snapshot
    assign sdc_rd_hit = sdc_en && slot_mem && !bus.rd_n && bus.addr[15:8] == sdc_window_page;

    always_comb begin
        sdc_rd_data = unmapped_byte;
        if (bus.addr == sdc_enable_addr) begin
            sdc_rd_data = {7'b0, sdc_en};
        end else if (bus.addr == sdc_status_addr) begin
            sdc_rd_data                     = '0;
            sdc_rd_data[status_busy_bit]    = sd_busy;
            sdc_rd_data[status_timeout_bit] = sd_timeout_error;
            sdc_rd_data[status_crc_bit]     = sd_crc_error;
        end
    end

    // a completing transfer must not immediately retrigger
    a_no_start_on_done: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        sd_done |=> !$rose(sd_rstart) && !$rose(sd_wstart));

endmodule

//--- verification/tb_msx_cart_top.sv
`timescale 1ns/10ps

module tb_msx_cart_top import msx_bus_pkg::*, sdc_pkg::*; ();

    localparam int    wait_limit  = 64;     // cycles per wait loop
    localparam int    hold_cycles = 24;
    localparam int    idle_cycles = 16;
    localparam byte_t ctl_idle    = 8'hFF;
    localparam byte_t ctl_mem     = 8'hFE;  // merq low
    localparam byte_t ctl_io      = 8'hFD;  // iorq low, m1 high
    localparam addr_t addr_idle   = 16'hFFFF;

    logic          clk108_w;
    logic          ram_enabled_w;
    byte_t         mp;
    wire [7:0]     cd;
    byte_t         cd_drv;
    logic          cd_oe;
    logic          rd_n;
    logic          wr_n;
    logic          sltsl_n;
    msel_t         msel_n;
    logic          datadir;
    logic          sd_busy;
    logic          sd_done;
    logic          sd_crc_error;
    logic          sd_timeout_error;
    logic          sd_rstart;
    logic          sd_wstart;
    logic          sd_init;
    sector_t       sd_sector;
    megaram_type_e megaram_type;
    logic          scc_enable;

    addr_t bus_addr;
    byte_t bus_ctl;
    int    err_count;
    int    timeout_count;
    int    check_count;
    int    seed;

    msx_cart_top i_msx_cart_top (
        .clk108_w         (clk108_w),
        .ram_enabled_w    (ram_enabled_w),
        .mp               (mp),
        .cd               (cd),
        .rd_n             (rd_n),
        .wr_n             (wr_n),
        .sltsl_n          (sltsl_n),
        .msel_n           (msel_n),
        .datadir          (datadir),
        .sd_busy          (sd_busy),
        .sd_done          (sd_done),
        .sd_crc_error     (sd_crc_error),
        .sd_timeout_error (sd_timeout_error),
        .sd_rstart        (sd_rstart),
        .sd_wstart        (sd_wstart),
        .sd_init          (sd_init),
        .sd_sector        (sd_sector),
        .megaram_type     (megaram_type),
        .scc_enable       (scc_enable)
    );

    initial clk108_w = 1'b0;
    always #20 clk108_w = ~clk108_w;

    assign cd = cd_oe ? cd_drv : 8'hzz;   // msx side drives only on writes

    // multiplexed bus model follows the select lines
    always_comb begin
        case (msel_n)
            3'b110:  mp = bus_addr[7:0];
            3'b101:  mp = bus_addr[15:8];
            3'b011:  mp = bus_ctl;
            default: mp = 8'hFF;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // timing and compare helpers

    task automatic tick();
        @(posedge clk108_w);
        #2;
    endtask

    task automatic tick_n(input int n);
        for (int i = 0; i < n; i++) tick();
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_sector(input string name, input sector_t got, input sector_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_type(input string name, input megaram_type_e got,
                              input megaram_type_e exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_msel(input string name, input msel_t got, input msel_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // 110 then 101, 011 and 111 for two clocks each
    function automatic msel_t expected_msel(input int step);
        case ((step / 2) % 4)
            0:       return 3'b110;
            1:       return 3'b101;
            2:       return 3'b011;
            default: return 3'b111;
        endcase
    endfunction

    function automatic byte_t compose_status(input logic busy, input logic tmo, input logic crc);
        byte_t s;
        s    = 8'h00;
        s[7] = busy;
        s[1] = tmo;
        s[0] = crc;
        return s;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // bus cycles

    task automatic bus_idle();
        bus_addr = addr_idle;   // a partial snapshot never hits a register
        bus_ctl  = ctl_idle;
        rd_n     = 1'b1;
        wr_n     = 1'b1;
        sltsl_n  = 1'b1;
        cd_oe    = 1'b0;
    endtask

    task automatic bus_mem_write(input addr_t a, input byte_t d);
        bus_addr = a;
        bus_ctl  = ctl_mem;
        sltsl_n  = 1'b0;
        wr_n     = 1'b0;
        cd_drv   = d;
        cd_oe    = 1'b1;
        tick_n(hold_cycles);
        bus_idle();
        tick_n(idle_cycles);
    endtask

    task automatic bus_mem_read(input addr_t a, input byte_t exp);
        int n;
        n        = 0;
        bus_addr = a;
        bus_ctl  = ctl_mem;
        sltsl_n  = 1'b0;
        rd_n     = 1'b0;
        tick_n(hold_cycles);
        while (datadir !== 1'b0 && n < wait_limit) begin
            tick();
            n++;
        end
        if (datadir !== 1'b0) begin
            timeout_count++;
            $display("timeout: datadir never went low during a read of %h", a);
        end
        check_byte("cd", cd, exp);
        check_bit("datadir", datadir, 1'b0);
        bus_idle();
        tick_n(idle_cycles);
    endtask

    task automatic bus_io_write(input byte_t port, input byte_t d);
        bus_addr = {8'h00, port};
        bus_ctl  = ctl_io;
        wr_n     = 1'b0;
        cd_drv   = d;
        cd_oe    = 1'b1;
        tick_n(hold_cycles);
        bus_idle();
        tick_n(idle_cycles);
    endtask

    task automatic pulse_sd_done();
        int n;
        n       = 0;
        sd_done = 1'b1;
        tick_n(hold_cycles);
        while ((sd_rstart !== 1'b0 || sd_wstart !== 1'b0) && n < wait_limit) begin
            tick();
            n++;
        end
        if (sd_rstart !== 1'b0 || sd_wstart !== 1'b0) begin
            timeout_count++;
            $display("timeout: start flags stayed set while sd_done was high");
        end
        sd_done = 1'b0;
        tick_n(idle_cycles);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic test_reset_sequence();
        ram_enabled_w    = 1'b0;
        sd_busy          = 1'b0;
        sd_done          = 1'b0;
        sd_crc_error     = 1'b0;
        sd_timeout_error = 1'b0;
        cd_drv           = 8'h00;
        bus_idle();
        tick_n(8);
        check_msel("msel_n", msel_n, 3'b111);
        check_bit("datadir", datadir, 1'b1);   // cd released
        check_bit("sd_rstart", sd_rstart, 1'b0);
        check_bit("sd_wstart", sd_wstart, 1'b0);
        check_bit("sd_init", sd_init, 1'b0);
        check_type("megaram_type", megaram_type, mt_konami);
        check_bit("scc_enable", scc_enable, 1'b0);
        ram_enabled_w = 1'b1;
        for (int i = 0; i < 16; i++) begin
            tick();
            check_msel("msel_n", msel_n, expected_msel(i));
        end
        bus_mem_read(16'h7E00, 8'hFF);   // window still disabled
    endtask

    task automatic test_enable_sector();
        byte_t b [4];
        logic [31:0] rnd;
        bus_mem_write(16'h7E00, 8'h01);
        bus_mem_read(16'h7E00, 8'h01);
        for (int i = 0; i < 4; i++) begin
            rnd  = $random(seed);
            b[i] = rnd[7:0];
            bus_mem_write(16'h7E03 + 16'(i), b[i]);
        end
        check_sector("sd_sector", sd_sector, {b[3], b[2], b[1], b[0]});
    endtask

    task automatic test_command_flags();
        bus_mem_write(16'h7E01, 8'h83);
        check_bit("sd_rstart", sd_rstart, 1'b1);
        check_bit("sd_init", sd_init, 1'b1);
        check_bit("sd_wstart", sd_wstart, 1'b1);   // 83h carries bit 1 too
        pulse_sd_done();
        check_bit("sd_rstart", sd_rstart, 1'b0);
        check_bit("sd_wstart", sd_wstart, 1'b0);
        check_bit("sd_init", sd_init, 1'b1);   // init survives done
        bus_mem_write(16'h7E01, 8'h02);
        check_bit("sd_wstart", sd_wstart, 1'b1);
        check_bit("sd_rstart", sd_rstart, 1'b0);
        pulse_sd_done();
        check_bit("sd_wstart", sd_wstart, 1'b0);
    endtask

    task automatic test_status_reads();
        sd_busy          = 1'b1;
        sd_timeout_error = 1'b0;
        sd_crc_error     = 1'b1;
        bus_mem_read(16'h7E02, compose_status(1'b1, 1'b0, 1'b1));
        sd_busy          = 1'b0;
        sd_timeout_error = 1'b1;
        sd_crc_error     = 1'b0;
        bus_mem_read(16'h7E02, compose_status(1'b0, 1'b1, 1'b0));
        bus_mem_read(16'h7E10, 8'hFF);
        bus_mem_write(16'h7E00, 8'h00);
        bus_mem_read(16'h7E02, 8'hFF);   // disabled again
        sd_timeout_error = 1'b0;
    endtask

    task automatic test_megaram_port();
        bus_io_write(8'h8F, 8'h05);
        check_type("megaram_type", megaram_type, mt_konami_scc);
        check_bit("scc_enable", scc_enable, 1'b1);
        bus_io_write(8'h8F, 8'h16);
        check_type("megaram_type", megaram_type, mt_ascii16);
        check_bit("scc_enable", scc_enable, 1'b0);
        bus_io_write(8'h8F, 8'h08);
        check_type("megaram_type", megaram_type, mt_ascii8);
        check_bit("scc_enable", scc_enable, 1'b0);
        bus_io_write(8'h8F, 8'h33);
        check_type("megaram_type", megaram_type, mt_konami);
        check_bit("scc_enable", scc_enable, 1'b0);
        // neighbouring port is ignored
        bus_io_write(8'h8E, 8'h05);
        check_type("megaram_type", megaram_type, mt_konami);
        check_bit("scc_enable", scc_enable, 1'b0);
    endtask

    initial begin
        err_count     = 0;
        timeout_count = 0;
        check_count   = 0;
        seed          = 32'h603b_f31e;
        test_reset_sequence();
        test_enable_sector();
        test_command_flags();
        test_status_reads();
        test_megaram_port();
        $display("checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
rtl/msx_bus_pkg.sv
rtl/sdc_pkg.sv
rtl/msx_bus_if.sv
rtl/msx_bus_sampler.sv
rtl/sdc_registers.sv
rtl/megaram_config.sv
rtl/cart_data_driver.sv
rtl/msx_cart_top.sv
verification/tb_msx_cart_top.sv
